/* verilog/mvu_pkg.sv */
`default_nettype none

package mvu_pkg;

    localparam int NLANE     = 4;
    localparam int NELEM     = 8;     // Elements per bit-plane word
    localparam int MEM_DEPTH = 64;
    localparam int ADDR_W    = 6;
    localparam int PREC_W    = 3;     // Precision minus one
    localparam int LEN_W     = 6;     // Length minus one, also result index
    localparam int LANE_W    = 2;
    localparam int ACC_W     = 20;
    localparam int SHIFT_W   = 4;     // Holds i + j up to 14

    typedef logic [NELEM-1:0] plane_t;

    typedef struct packed {
        logic [LANE_W-1:0] lane;
        logic              target;    // 1 weight memory, 0 data memory
        logic [ADDR_W-1:0] addr;
        plane_t            word;
    } mem_wr_t;

    typedef struct packed {
        logic [ADDR_W-1:0] wbase;
        logic [ADDR_W-1:0] ibase;
        logic [PREC_W-1:0] wprec;
        logic [PREC_W-1:0] iprec;
        logic [LEN_W-1:0]  len;
        logic              wsigned;
        logic              dsigned;
    } job_cfg_t;

    typedef struct packed {
        logic [LANE_W-1:0] lane;
        job_cfg_t          cfg;
    } job_req_t;

    typedef struct packed {
        logic [LANE_W-1:0]       lane;
        logic [LEN_W-1:0]        idx;
        logic signed [ACC_W-1:0] value;
    } result_t;

    // Travels alongside one memory read
    typedef struct packed {
        logic [SHIFT_W-1:0] shift;
        logic               neg;
        logic               first;
        logic               last;
        logic [LEN_W-1:0]   idx;
    } agu_tag_t;

endpackage

`default_nettype wire

/* verilog/bank_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module bank_ram (
    input  logic                        clk,
    input  logic                        wr_en,
    input  logic [mvu_pkg::ADDR_W-1:0]  wr_addr,
    input  mvu_pkg::plane_t             wr_word,
    input  logic [mvu_pkg::ADDR_W-1:0]  rd_addr,
    output mvu_pkg::plane_t             rd_word
);
    import mvu_pkg::*;

    plane_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
        rd_word <= mem[rd_addr];   // Registered read
    end

endmodule

`default_nettype wire

/* verilog/bitplane_agu.sv */
`timescale 1ns/1ns
`default_nettype none

module bitplane_agu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  mvu_pkg::job_cfg_t           cfg,
    input  logic                        hold,
    output logic [mvu_pkg::ADDR_W-1:0]  waddr,
    output logic [mvu_pkg::ADDR_W-1:0]  iaddr,
    output mvu_pkg::agu_tag_t           tag,
    output logic                        tag_valid,
    output logic                        done
);
    import mvu_pkg::*;

    logic                running;
    logic [LEN_W-1:0]    out_idx;
    logic [PREC_W-1:0]   wbit;
    logic [PREC_W-1:0]   ibit;
    logic [ADDR_W-1:0]   wvec;      // Base of current weight row
    logic [ADDR_W-1:0]   ivec;      // Base of current input vector
    logic                last_i;
    logic                last_w;
    logic                last_out;
    logic                issue;
    agu_tag_t            tag_d;

    assign last_i   = (ibit == cfg.iprec);
    assign last_w   = (wbit == cfg.wprec);
    assign last_out = (out_idx == cfg.len);

    // Hold only bites at the start of an output
    assign issue = running && !(hold && tag_d.first);

    assign waddr = wvec + ADDR_W'(wbit);
    assign iaddr = ivec + ADDR_W'(ibit);

    always_comb begin
        tag_d.shift = SHIFT_W'(wbit) + SHIFT_W'(ibit);
        tag_d.neg   = (cfg.dsigned && last_i) ^ (cfg.wsigned && last_w);
        tag_d.first = (ibit == '0) && (wbit == '0);
        tag_d.last  = last_i && last_w;
        tag_d.idx   = out_idx;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            out_idx <= '0;
            wbit    <= '0;
            ibit    <= '0;
            wvec    <= '0;
            ivec    <= '0;
        end else if (start) begin
            running <= 1'b1;
            out_idx <= '0;
            wbit    <= '0;
            ibit    <= '0;
            wvec    <= cfg.wbase;
            ivec    <= cfg.ibase;
        end else if (issue) begin
            if (!last_i) begin
                ibit <= ibit + 1'b1;   // Input bit runs innermost
            end else begin
                ibit <= '0;
                if (!last_w) begin
                    wbit <= wbit + 1'b1;
                end else begin
                    wbit <= '0;
                    if (last_out) begin
                        running <= 1'b0;
                    end else begin
                        out_idx <= out_idx + 1'b1;
                        wvec    <= wvec + ADDR_W'(cfg.wprec) + 1'b1;
                        ivec    <= ivec + ADDR_W'(cfg.iprec) + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            tag_valid <= issue;
            done      <= issue && last_i && last_w && last_out;
        end
    end

    // Lines up with the one-cycle memory read
    always_ff @(posedge clk) begin
        tag <= tag_d;
    end

endmodule

`default_nettype wire

/* verilog/serial_dot_acc.sv */
`timescale 1ns/1ns
`default_nettype none

module serial_dot_acc (
    input  logic               clk,
    input  logic               rst_n,
    input  mvu_pkg::plane_t    dword,
    input  mvu_pkg::plane_t    wword,
    input  mvu_pkg::agu_tag_t  tag,
    input  logic               tag_valid,
    output mvu_pkg::result_t   res,
    output logic               res_valid,
    input  logic               res_ready,
    output logic               full
);
    import mvu_pkg::*;

    plane_t                   both;
    logic [ACC_W-1:0]         cnt;
    logic [ACC_W-1:0]         shifted;
    logic signed [ACC_W-1:0]  term;
    logic signed [ACC_W-1:0]  sum;
    logic signed [ACC_W-1:0]  acc;
    logic [LEN_W-1:0]         buf_idx;
    logic signed [ACC_W-1:0]  buf_value;

    always_comb begin
        both = dword & wword;
        cnt  = '0;
        for (int k = 0; k < NELEM; k++) begin
            cnt = cnt + ACC_W'(both[k]);   // Popcount
        end
        shifted = cnt << tag.shift;
        term    = tag.neg ? -$signed(shifted) : $signed(shifted);
        sum     = tag.first ? term : acc + term;
    end

    // Buffer taken next cycle, or a sum landing in it now
    assign full = (res_valid && !res_ready) || (tag_valid && tag.last);

    always_ff @(posedge clk) begin
        if (tag_valid) begin
            acc <= sum;
            if (tag.last) begin
                buf_idx   <= tag.idx;
                buf_value <= sum;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (tag_valid && tag.last) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    // Lane field filled in by the lane
    assign res = '{lane: '0, idx: buf_idx, value: buf_value};

endmodule

`default_nettype wire

/* verilog/mvu_lane.sv */
`timescale 1ns/1ns
`default_nettype none

module mvu_lane (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [mvu_pkg::LANE_W-1:0]  lane_id,
    input  logic                        wr_en,
    input  mvu_pkg::mem_wr_t            wr,
    input  logic                        start,
    input  mvu_pkg::job_cfg_t           cfg,
    output logic                        busy,
    output mvu_pkg::result_t            res,
    output logic                        res_valid,
    input  logic                        res_ready
);
    import mvu_pkg::*;

    logic [ADDR_W-1:0]  waddr;
    logic [ADDR_W-1:0]  iaddr;
    plane_t             wword;
    plane_t             dword;
    agu_tag_t           tag;
    logic               tag_valid;
    logic               gen_end;
    logic               gen_done;   // Address generator finished this job
    logic               full;
    result_t            acc_res;

    bank_ram u_wmem (
        .clk     (clk),
        .wr_en   (wr_en && wr.target),
        .wr_addr (wr.addr),
        .wr_word (wr.word),
        .rd_addr (waddr),
        .rd_word (wword)
    );

    bank_ram u_dmem (
        .clk     (clk),
        .wr_en   (wr_en && !wr.target),
        .wr_addr (wr.addr),
        .wr_word (wr.word),
        .rd_addr (iaddr),
        .rd_word (dword)
    );

    bitplane_agu u_agu (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cfg       (cfg),
        .hold      (full),        // Gated by the first-term flag inside
        .waddr     (waddr),
        .iaddr     (iaddr),
        .tag       (tag),
        .tag_valid (tag_valid),
        .done      (gen_end)
    );

    serial_dot_acc u_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .dword     (dword),
        .wword     (wword),
        .tag       (tag),
        .tag_valid (tag_valid),
        .res       (acc_res),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .full      (full)
    );

    assign res = '{lane: lane_id, idx: acc_res.idx, value: acc_res.value};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            gen_done <= 1'b0;
        end else if (start) begin
            busy     <= 1'b1;
            gen_done <= 1'b0;
        end else begin
            if (gen_end) begin
                gen_done <= 1'b1;
            end
            // Last result leaves the buffer
            if (gen_done && !tag_valid && (!res_valid || res_ready)) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/job_dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

module job_dispatch (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  mvu_pkg::mem_wr_t                       mem_wr,
    input  logic                                   mem_wr_en,
    input  mvu_pkg::job_req_t                      job,
    input  logic                                   job_valid,
    output logic                                   job_ready,
    input  logic [mvu_pkg::NLANE-1:0]              busy,
    output logic [mvu_pkg::NLANE-1:0]              lane_wr_en,
    output mvu_pkg::mem_wr_t                       lane_wr,
    output logic [mvu_pkg::NLANE-1:0]              start,
    output mvu_pkg::job_cfg_t [mvu_pkg::NLANE-1:0] cfg
);
    import mvu_pkg::*;

    logic                 job_fire;
    logic [NLANE-1:0]     wr_sel;
    logic [NLANE-1:0]     job_sel;

    // A pending start also counts as busy, busy only rises a cycle later
    assign job_ready = !busy[job.lane] && !start[job.lane];
    assign job_fire  = job_valid && job_ready;

    always_comb begin
        for (int i = 0; i < NLANE; i++) begin
            wr_sel[i]  = mem_wr_en && (mem_wr.lane == LANE_W'(i));
            job_sel[i] = job_fire && (job.lane == LANE_W'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_wr_en <= '0;
            start      <= '0;
        end else begin
            lane_wr_en <= wr_sel;
            start      <= job_sel;   // One-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            lane_wr <= mem_wr;
        end
        for (int i = 0; i < NLANE; i++) begin
            if (job_sel[i]) begin
                cfg[i] <= job.cfg;   // Held for the whole job
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/result_collect.sv */
`timescale 1ns/1ns
`default_nettype none

module result_collect (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  mvu_pkg::result_t [mvu_pkg::NLANE-1:0] res,
    input  logic [mvu_pkg::NLANE-1:0]             res_valid,
    output logic [mvu_pkg::NLANE-1:0]             res_ready,
    output mvu_pkg::result_t                      result,
    output logic                                  result_valid,
    input  logic                                  result_ready
);
    import mvu_pkg::*;

    logic [LANE_W-1:0]  last_ptr;   // Lane served most recently
    logic [LANE_W-1:0]  cand;
    logic [LANE_W-1:0]  pick;
    logic               pick_valid;
    logic               load;

    // Search starts just after the last lane served, wrapping round
    always_comb begin
        pick       = last_ptr;
        pick_valid = 1'b0;
        cand       = last_ptr;
        for (int k = 1; k <= NLANE; k++) begin
            cand = last_ptr + LANE_W'(k);
            if (!pick_valid && res_valid[cand]) begin
                pick       = cand;
                pick_valid = 1'b1;
            end
        end
    end

    assign load = pick_valid && (!result_valid || result_ready);

    always_comb begin
        for (int k = 0; k < NLANE; k++) begin
            res_ready[k] = load && (pick == LANE_W'(k));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            last_ptr     <= '1;       // Lane 0 goes first
        end else if (load) begin
            result_valid <= 1'b1;
            last_ptr     <= pick;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            result <= res[pick];
        end
    end

endmodule

`default_nettype wire

/* verilog/mvu_array.sv */
`timescale 1ns/1ns
`default_nettype none

module mvu_array (
    input  logic               clk,
    input  logic               rst_n,
    input  mvu_pkg::mem_wr_t   mem_wr,
    input  logic               mem_wr_en,
    input  mvu_pkg::job_req_t  job,
    input  logic               job_valid,
    output logic               job_ready,
    output mvu_pkg::result_t   result,
    output logic               result_valid,
    input  logic               result_ready
);
    import mvu_pkg::*;

    logic [NLANE-1:0]      lane_wr_en;
    mem_wr_t               lane_wr;      // Shared by all lanes
    logic [NLANE-1:0]      start;
    job_cfg_t [NLANE-1:0]  cfg;
    logic [NLANE-1:0]      busy;
    result_t [NLANE-1:0]   lane_res;
    logic [NLANE-1:0]      lane_res_valid;
    logic [NLANE-1:0]      lane_res_ready;

    job_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_wr     (mem_wr),
        .mem_wr_en  (mem_wr_en),
        .job        (job),
        .job_valid  (job_valid),
        .job_ready  (job_ready),
        .busy       (busy),
        .lane_wr_en (lane_wr_en),
        .lane_wr    (lane_wr),
        .start      (start),
        .cfg        (cfg)
    );

    for (genvar g = 0; g < NLANE; g++) begin : g_lane
        mvu_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .lane_id   (LANE_W'(g)),
            .wr_en     (lane_wr_en[g]),
            .wr        (lane_wr),
            .start     (start[g]),
            .cfg       (cfg[g]),
            .busy      (busy[g]),
            .res       (lane_res[g]),
            .res_valid (lane_res_valid[g]),
            .res_ready (lane_res_ready[g])
        );
    end

    result_collect u_collect (
        .clk          (clk),
        .rst_n        (rst_n),
        .res          (lane_res),
        .res_valid    (lane_res_valid),
        .res_ready    (lane_res_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;   // 8 ns period

endmodule

`default_nettype wire

/* verif/mvu_array_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mvu_array_tb;
    import mvu_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic         clk;
    logic         rst_n;
    mem_wr_t      mem_wr;
    logic         mem_wr_en;
    job_req_t     job;
    logic         job_valid;
    logic         job_ready;
    result_t      result;
    logic         result_valid;
    logic         result_ready;

    result_t      expq[$];      // Expected results, oldest first
    int           fresh_exp[NLANE];   // Expected results queued for the next job of a lane
    int           errors;
    int           test_err_base;
    int           pass_cnt;
    int           fail_cnt;
    logic         aborted;
    logic         rand_ready;
    integer       seed;
    logic [31:0]  rnd;

    tb_clock u_clock (
        .clk (clk)
    );

    mvu_array mvu_array_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_wr       (mem_wr),
        .mem_wr_en    (mem_wr_en),
        .job          (job),
        .job_valid    (job_valid),
        .job_ready    (job_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic int count_pending(input int lane);
        int n;
        n = 0;
        foreach (expq[k]) begin
            if (expq[k].lane == LANE_W'(lane)) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic finish_test(input int test);
        if (errors == test_err_base) begin
            pass_cnt++;
            $display("test %0d passed", test);
        end else begin
            fail_cnt++;
            $display("test %0d failed with %0d errors", test, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    task automatic write_mem(input int lane, input int target, input int addr, input int word);
        @(negedge clk);
        mem_wr.lane   = LANE_W'(lane);
        mem_wr.target = target[0];
        mem_wr.addr   = ADDR_W'(addr);
        mem_wr.word   = NELEM'(word);
        mem_wr_en     = 1'b1;
        @(negedge clk);
        mem_wr_en     = 1'b0;
    endtask

    // Bit counts and length come in as real values, fields hold them minus one
    task automatic send_job(input int test, input int lane, input int wbase, input int ibase,
                            input int wbits, input int ibits, input int len,
                            input int wsig, input int dsig);
        int waited;
        int pending;
        @(negedge clk);
        rand_ready      = (test == 5);
        job.lane        = LANE_W'(lane);
        job.cfg.wbase   = ADDR_W'(wbase);
        job.cfg.ibase   = ADDR_W'(ibase);
        job.cfg.wprec   = PREC_W'(wbits - 1);
        job.cfg.iprec   = PREC_W'(ibits - 1);
        job.cfg.len     = LEN_W'(len - 1);
        job.cfg.wsigned = (wsig != 0);
        job.cfg.dsigned = (dsig != 0);
        job_valid       = 1'b1;
        waited          = 0;
        #1;
        while (!job_ready && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!job_ready) begin
            $display("job for lane %0d was never accepted", lane);
            aborted = 1'b1;
        end else begin
            // At most the last result may still sit in the collector
            pending = count_pending(lane) - fresh_exp[lane];
            if (pending > 1) begin
                $display("lane %0d took a new job with %0d results not handed off",
                         lane, pending);
                errors++;
            end
            fresh_exp[lane] = 0;
            @(posedge clk);
        end
        @(negedge clk);
        job_valid = 1'b0;
    endtask

    task automatic wait_drain(input int test);
        int waited;
        waited = 0;
        while (expq.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (expq.size() != 0) begin
            $display("test %0d timed out with %0d results missing", test, expq.size());
            aborted = 1'b1;
        end
        finish_test(test);
    endtask

    // Oldest pending entry of the same lane must match, which keeps index order
    task automatic take_result(input result_t r);
        int k;
        k = -1;
        foreach (expq[n]) begin
            if (k < 0 && expq[n].lane == r.lane) begin
                k = n;
            end
        end
        if (k < 0) begin
            $display("lane %0d gave an unexpected result at index %0d", r.lane, r.idx);
            errors++;
        end else begin
            check_value("result.idx", r.idx, expq[k].idx);
            check_value("result.value", $unsigned(r.value), $unsigned(expq[k].value));
            expq.delete(k);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && result_valid && result_ready) begin
            take_result(result);
        end
    end

    always @(negedge clk) begin
        rnd          = $random(seed);
        result_ready = rand_ready ? rnd[0] : 1'b1;
    end

    initial begin
        integer                fd;
        integer                code;
        logic [8*8-1:0]        kind;
        logic [8*160-1:0]      line;
        int                    t_num;
        int                    lane_n;
        int                    tgt;
        int                    addr_v;
        int                    word_v;
        int                    wbase;
        int                    ibase;
        int                    wbits;
        int                    ibits;
        int                    len_v;
        int                    ws;
        int                    ds;
        int                    idx_v;
        logic [31:0]           val_v;

        seed          = 2998;
        errors        = 0;
        test_err_base = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        aborted       = 1'b0;
        rand_ready    = 1'b0;
        mem_wr        = '0;
        mem_wr_en     = 1'b0;
        job           = '0;
        job_valid     = 1'b0;
        result_ready  = 1'b1;
        rst_n         = 1'b0;
        foreach (fresh_exp[k]) begin
            fresh_exp[k] = 0;
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("result_valid", result_valid, 0);
        check_value("job_ready", job_ready, 1);
        finish_test(1);

        fd = $fopen("verif/mvu_array_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file");
            aborted = 1'b1;
        end else begin
            while (!aborted && $fscanf(fd, "%s", kind) == 1) begin
                case (kind)
                    "W": begin
                        code = $fscanf(fd, "%d %d %h %h", lane_n, tgt, addr_v, word_v);
                        if (code == 4) begin
                            write_mem(lane_n, tgt, addr_v, word_v);
                        end else begin
                            $display("write record in the cases file is incomplete");
                            aborted = 1'b1;
                        end
                    end
                    "E": begin
                        code = $fscanf(fd, "%d %d %h", lane_n, idx_v, val_v);
                        if (code == 3) begin
                            expq.push_back('{lane: LANE_W'(lane_n), idx: LEN_W'(idx_v),
                                             value: val_v[ACC_W-1:0]});
                            fresh_exp[lane_n]++;
                        end else begin
                            $display("expected record in the cases file is incomplete");
                            aborted = 1'b1;
                        end
                    end
                    "J": begin
                        code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d", t_num, lane_n,
                                       wbase, ibase, wbits, ibits, len_v, ws, ds);
                        if (code == 9) begin
                            send_job(t_num, lane_n, wbase, ibase, wbits, ibits, len_v,
                                     ws, ds);
                        end else begin
                            $display("job record in the cases file is incomplete");
                            aborted = 1'b1;
                        end
                    end
                    "R": begin
                        code = $fscanf(fd, "%d", t_num);
                        if (code == 1) begin
                            wait_drain(t_num);
                        end else begin
                            $display("drain record in the cases file is incomplete");
                            aborted = 1'b1;
                        end
                    end
                    "#": begin
                        code = $fgets(line, fd);
                    end
                    default: begin
                        $display("unknown record kind in the cases file");
                        aborted = 1'b1;
                    end
                endcase
            end
            $fclose(fd);
        end

        if (!aborted && expq.size() != 0) begin
            $display("%0d expected results were left over", expq.size());
            errors++;
        end
        $display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, errors);
        if (errors == 0 && !aborted) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/mvu_array_cases.txt */
# W lane target(1 weight, 0 data) addr word | E lane index value | R test drains
# J test lane wbase ibase wbits ibits length wsigned dsigned (real sizes, not minus one)
W 0 0 0 03
W 0 0 1 01
W 0 0 2 02
W 0 0 3 00
W 0 0 4 ff
W 0 0 5 ff
W 0 0 6 ff
W 0 0 7 ff
W 0 0 8 80
W 0 0 9 80
W 0 0 a 80
W 0 0 b 80
W 0 0 c 0f
W 0 0 d 00
W 0 0 e 00
W 0 0 f 0f
W 0 1 0 00
W 0 1 1 01
W 0 1 2 02
W 0 1 3 00
W 0 1 4 ff
W 0 1 5 00
W 0 1 6 00
W 0 1 7 00
W 0 1 8 80
W 0 1 9 80
W 0 1 a 80
W 0 1 b 80
W 0 1 c 00
W 0 1 d 0f
W 0 1 e 0f
W 0 1 f 00
E 0 0 1a
E 0 1 78
E 0 2 e1
E 0 3 d8
J 2 0 0 0 4 4 4 0 0
R 2
W 1 0 0 03
W 1 0 1 02
W 1 0 2 01
W 1 0 3 01
W 1 1 0 01
W 1 1 1 02
W 1 1 2 03
W 1 1 3 02
W 1 0 4 0f
W 1 1 4 1c
W 1 1 5 08
W 1 1 6 1a
W 1 1 7 19
W 1 1 8 08
W 1 1 9 0a
W 1 1 a 1b
W 1 1 b 09
E 1 0 1b
J 3 1 0 0 4 4 1 0 1
E 1 0 3b
J 3 1 0 0 4 4 1 1 0
E 1 0 fffeb
J 3 1 0 0 4 4 1 1 1
E 1 0 2c
J 3 1 4 4 8 1 1 1 0
R 3
W 2 0 0 01
W 2 0 1 03
W 2 0 2 ff
W 2 0 3 00
W 2 1 0 03
W 2 1 1 02
W 2 1 2 00
W 2 1 3 ff
W 3 0 0 01
W 3 0 1 03
W 3 0 2 ff
W 3 0 3 00
W 3 1 0 03
W 3 1 1 02
W 3 1 2 00
W 3 1 3 ff
E 0 0 5a
E 0 1 0f
E 1 0 6b
E 2 0 9
E 2 1 10
E 3 0 1
E 3 1 ffff0
J 4 0 0 4 4 4 2 0 0
J 4 1 0 0 4 4 1 0 0
J 4 2 0 0 2 2 2 0 0
J 4 3 0 0 2 2 2 1 1
R 4
E 2 0 9
E 2 1 10
J 5 2 0 0 2 2 2 0 0
E 3 0 1
E 3 1 ffff0
J 5 3 0 0 2 2 2 1 1
J 5 2 0 0 2 2 2 0 1
E 2 0 ffff9
E 2 1 10
R 5

/* mvu_array.f */
verilog/mvu_pkg.sv
verilog/bank_ram.sv
verilog/bitplane_agu.sv
verilog/serial_dot_acc.sv
verilog/mvu_lane.sv
verilog/job_dispatch.sv
verilog/result_collect.sv
verilog/mvu_array.sv
verif/tb_clock.sv
verif/mvu_array_tb.sv

/* Bender.yml */
package:
  name: mvu_array

sources:
  - verilog/mvu_pkg.sv
  - verilog/bank_ram.sv
  - verilog/bitplane_agu.sv
  - verilog/serial_dot_acc.sv
  - verilog/mvu_lane.sv
  - verilog/job_dispatch.sv
  - verilog/result_collect.sv
  - verilog/mvu_array.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/mvu_array_tb.sv
